// File: src/cbm2_timing_pkg.sv
package cbm2_timing_pkg;

   // ============================================================
   // Bus slot map
   // ============================================================

   // One frame runs through these slots in order
   // Professional frames stop after VID3, Business frames after VID5
   typedef enum logic [4:0] {
      EXT0, EXT1, EXT2, EXT3,
      CPU0, CPU1, CPU2, CPU3,
      EXT4, EXT5, EXT6, EXT7,
      VID0, VID1, VID2, VID3,
      VID4, VID5
   } sys_cycle_t;

   // Final slot per model
   localparam sys_cycle_t PROF_LAST = VID3;
   localparam sys_cycle_t BUS_LAST  = VID5;

   // ============================================================
   // Refresh and TOD constants
   // ============================================================

   // Frame counter width, one refresh every 2**3 frames
   localparam int REFRESH_DIV_W = 3;

   // Frame count at which EXT0..EXT3 go to DRAM refresh
   // instead of the I/O controller
   localparam logic [REFRESH_DIV_W-1:0] REFRESH_SLOT_SKIP = 3'd1;

   // Accumulator steps, twice the tick rate since the output toggles
   localparam logic [31:0] TOD_STEP_NTSC = 32'd120;
   localparam logic [31:0] TOD_STEP_PAL  = 32'd100;

endpackage

// File: src/cycle_if.sv
`timescale 1ns/1ps

// Sequencer state shared with the timing consumers
interface cycle_if import cbm2_timing_pkg::*; ();

   // Effective slot, parked on EXT0 while paused
   sys_cycle_t sys_cycle;
   // Toggles on each frame wrap
   logic       phase;
   // Machine running (not paused)
   logic       sys_enable;
   // Final slot of the current frame
   logic       frame_last;

   // Sequencer drives everything
   modport seq (output sys_cycle, output phase, output sys_enable, output frame_last);

   // CRTC dot serializer
   modport dots (input sys_cycle, input sys_enable, input frame_last);

   // Time-of-day generator
   modport tod (input sys_enable);

endinterface

// File: src/cycle_sequencer.sv
`timescale 1ns/1ps

module cycle_sequencer import cbm2_timing_pkg::*; (
   input  logic clk_sys,
   input  logic reset,
   // 0 = Professional (16 slots), 1 = Business (18 slots)
   input  logic model_i,
   input  logic pause_i,
   input  logic cpu_2mhz_i,
   cycle_if.seq cyc,
   output logic cpu_enable_o,
   output logic io_cycle_o,
   output logic refresh_o,
   output logic pause_o
);

   // ============================================================
   // State
   // ============================================================

   // Free-running slot, keeps counting even while paused
   sys_cycle_t pre_cycle;
   // Effective slot seen by the rest of the system
   sys_cycle_t sys_cycle;
   sys_cycle_t last_cycle;

   logic phase;
   logic sys_enable;
   logic sys_2mhz;
   logic frame_end;
   logic cpu_phase;

   // Frames since last refresh
   logic [REFRESH_DIV_W-1:0] rfsh_cnt;

   // Frame length follows the model pin
   assign last_cycle = model_i ? BUS_LAST : PROF_LAST;
   assign frame_end  = (pre_cycle == last_cycle);

   // Paused machine sits on EXT0
   assign sys_cycle = sys_enable ? pre_cycle : EXT0;

   // ============================================================
   // Slot counter, phase and latched settings
   // ============================================================

   always_ff @(posedge clk_sys) begin
      if (reset) begin
         pre_cycle  <= EXT0;
         phase      <= 1'b0;
         sys_enable <= 1'b0;
         sys_2mhz   <= 1'b0;
         rfsh_cnt   <= '0;
         refresh_o  <= 1'b0;
      end else begin
         // Refresh is a one-cycle pulse
         refresh_o <= 1'b0;

         if (frame_end) begin
            pre_cycle <= EXT0;
            phase     <= ~phase;

            // Pause and speed only change at the end of a whole
            // CPU period, i.e. after the phase-1 frame
            if (phase) begin
               sys_enable <= ~pause_i;
               sys_2mhz   <= cpu_2mhz_i;
            end

            rfsh_cnt <= rfsh_cnt + 1'b1;
            if (rfsh_cnt == '0) begin
               refresh_o <= 1'b1;
            end
         end else begin
            pre_cycle <= sys_cycle_t'(pre_cycle + 5'd1);
         end
      end
   end

   // ============================================================
   // Strobes
   // ============================================================

   // At 2 MHz the CPU gets every frame, at 1 MHz every other one
   assign cpu_phase = phase | sys_2mhz;

   // CPU clock enable at the end of the CPU slot group
   assign cpu_enable_o = (sys_cycle == CPU3) && cpu_phase;

   // I/O controller owns both EXT groups
   // First group goes to refresh once every 8 frames
   always_comb begin
      io_cycle_o = 1'b0;
      if (sys_cycle <= EXT3 && rfsh_cnt != REFRESH_SLOT_SKIP) begin
         io_cycle_o = 1'b1;
      end
      if (sys_cycle >= EXT4 && sys_cycle <= EXT7) begin
         io_cycle_o = 1'b1;
      end
   end

   assign pause_o = ~sys_enable;

   // ============================================================
   // Interface outputs
   // ============================================================

   assign cyc.sys_cycle  = sys_cycle;
   assign cyc.phase      = phase;
   assign cyc.sys_enable = sys_enable;
   // Frame end of the raw counter, valid while paused too
   assign cyc.frame_last = frame_end;

endmodule

// File: src/tod_clock.sv
`timescale 1ns/1ps

module tod_clock import cbm2_timing_pkg::*; #(
   // System clock frequency in Hz
   parameter int CLK_HZ = 2400
) (
   input  logic clk_sys,
   input  logic reset,
   // 1 = 60 Hz, 0 = 50 Hz
   input  logic ntsc_i,
   cycle_if.tod cyc,
   output logic tod_o
);

   localparam logic [31:0] CLK_LIMIT = CLK_HZ;

   logic [31:0] acc;
   logic [31:0] acc_sum;

   // Step is twice the tick rate, each overflow flips the output
   assign acc_sum = acc + (ntsc_i ? TOD_STEP_NTSC : TOD_STEP_PAL);

   // ============================================================
   // Fractional divider
   // ============================================================

   always_ff @(posedge clk_sys) begin
      if (reset) begin
         acc   <= '0;
         tod_o <= 1'b0;
      end else if (cyc.sys_enable) begin
         // Remainder carried over keeps the long-term rate exact
         if (acc_sum >= CLK_LIMIT) begin
            acc   <= acc_sum - CLK_LIMIT;
            tod_o <= ~tod_o;
         end else begin
            acc <= acc_sum;
         end
      end
   end

endmodule

// File: src/crtc_dot_serializer.sv
`timescale 1ns/1ps

module crtc_dot_serializer import cbm2_timing_pkg::*; (
   input  logic       clk_sys,
   input  logic       reset,
   cycle_if.dots      cyc,
   // Character ROM byte, MSB is the leftmost pixel
   input  logic [7:0] dots_i,
   // CRTC display enable and cursor
   input  logic       de_i,
   input  logic       cursor_i,
   // Reverse video for this character
   input  logic       reverse_i,
   // Graphics mode repeats the last pixel
   input  logic       graphics_i,
   output logic       dot_o
);

   // ============================================================
   // Pixel enable
   // ============================================================

   // Restarts every frame so pixel timing lines up with VID5
   logic [1:0] pix_cnt;

   always_ff @(posedge clk_sys) begin
      if (reset || !cyc.sys_enable || cyc.frame_last) begin
         pix_cnt <= 2'd0;
      end else begin
         pix_cnt <= pix_cnt + 2'd1;
      end
   end

   // ============================================================
   // Shift register and attributes
   // ============================================================

   logic [7:0] dot_sr;
   logic       rev_r;
   logic       de_r;
   logic       cursor_r;

   // Attribute latches cleared so the output stays dark until loaded
   always_ff @(posedge clk_sys) begin
      if (reset) begin
         de_r     <= 1'b0;
         cursor_r <= 1'b0;
      end else if (cyc.sys_cycle == VID5) begin
         de_r     <= de_i;
         cursor_r <= cursor_i;
      end
   end

   always_ff @(posedge clk_sys) begin
      // Shift out MSB first, refill with the low bit in graphics mode
      if (pix_cnt[0]) begin
         dot_sr <= {dot_sr[6:0], dot_sr[0] & graphics_i};
      end
      // New character loads in the last video slot, wins over shifting
      if (cyc.sys_cycle == VID5) begin
         dot_sr <= dots_i;
         rev_r  <= reverse_i;
      end
   end

   // Cursor inverts, DE blanks, reverse flips the pixel
   always_ff @(posedge clk_sys) begin
      if (reset) begin
         dot_o <= 1'b0;
      end else if (pix_cnt[0]) begin
         dot_o <= cursor_r ^ (de_r & (rev_r ^ dot_sr[7]));
      end
   end

endmodule

// File: src/cbm2_timing_top.sv
`timescale 1ns/1ps

module cbm2_timing_top #(
   // System clock frequency in Hz, small default for simulation
   parameter int CLK_HZ = 2400
) (
   input  logic       clk_sys,
   input  logic       reset,

   // Machine configuration
   // 0 = Professional, 1 = Business
   input  logic       model_i,
   // 0 = PAL 50 Hz, 1 = NTSC 60 Hz
   input  logic       ntsc_i,
   input  logic       pause_i,
   input  logic       cpu_2mhz_i,

   // CRTC side, character ROM data and attributes
   input  logic [7:0] dots_i,
   input  logic       de_i,
   input  logic       cursor_i,
   input  logic       reverse_i,
   input  logic       graphics_i,

   // Bus timing strobes
   output logic       cpu_enable_o,
   output logic       io_cycle_o,
   output logic       refresh_o,
   output logic       pause_o,

   // Time-of-day and pixel output
   output logic       tod_o,
   output logic       dot_o
);

   // Sequencer state bundle
   cycle_if cyc ();

   // ============================================================
   // Master cycle sequencer
   // ============================================================

   cycle_sequencer u_seq (
      .clk_sys      (clk_sys),
      .reset        (reset),
      .model_i      (model_i),
      .pause_i      (pause_i),
      .cpu_2mhz_i   (cpu_2mhz_i),
      .cyc          (cyc.seq),
      .cpu_enable_o (cpu_enable_o),
      .io_cycle_o   (io_cycle_o),
      .refresh_o    (refresh_o),
      .pause_o      (pause_o)
   );

   // 50/60 Hz tick for the CIA TOD input
   tod_clock #(
      .CLK_HZ (CLK_HZ)
   ) u_tod (
      .clk_sys (clk_sys),
      .reset   (reset),
      .ntsc_i  (ntsc_i),
      .cyc     (cyc.tod),
      .tod_o   (tod_o)
   );

   // Business model green-screen pixels
   crtc_dot_serializer u_dots (
      .clk_sys    (clk_sys),
      .reset      (reset),
      .cyc        (cyc.dots),
      .dots_i     (dots_i),
      .de_i       (de_i),
      .cursor_i   (cursor_i),
      .reverse_i  (reverse_i),
      .graphics_i (graphics_i),
      .dot_o      (dot_o)
   );

endmodule

// File: tb/tb_cbm2_timing.sv
`timescale 1ns/1ps

module tb_cbm2_timing;

   // Phases below take about 2900 cycles
   localparam int MAX_CYCLES = 4000;

   logic        clk_sys, reset, model_i, ntsc_i, pause_i, cpu_2mhz_i;
   logic        de_i, cursor_i, reverse_i, graphics_i;
   logic [7:0]  dots_i;
   logic        cpu_enable_o, io_cycle_o, refresh_o, pause_o, tod_o, dot_o;

   // Reference counters and expected values
   int          cycles = 0;
   int          rfsh_gap = 0, cpu_cnt = 0, tgap = 0, pin_cnt = 0;
   int          rfsh_expect = 0, cpu_expect = 0, tod_expect = 0;
   int          frame_len;
   int          seed = 32'h6720_de5e;
   logic        rst_d = 1'b0, tod_prev = 1'b0, pause_prev = 1'b0;
   logic        pause_chk = 1'b0, dot_chk = 1'b0, dot_want = 1'b0;
   logic [31:0] rnd;
   logic [5:0]  out_vec;

   cbm2_timing_top #(.CLK_HZ(2400)) uut (
      .clk_sys(clk_sys), .reset(reset), .model_i(model_i), .ntsc_i(ntsc_i),
      .pause_i(pause_i), .cpu_2mhz_i(cpu_2mhz_i), .dots_i(dots_i), .de_i(de_i),
      .cursor_i(cursor_i), .reverse_i(reverse_i), .graphics_i(graphics_i),
      .cpu_enable_o(cpu_enable_o), .io_cycle_o(io_cycle_o), .refresh_o(refresh_o),
      .pause_o(pause_o), .tod_o(tod_o), .dot_o(dot_o)
   );

   initial begin
      clk_sys = 1'b0;
      forever #50 clk_sys = ~clk_sys;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input int exp, input int act);
      report_failure($sformatf("MISMATCH at %0t: %s expected %0d actual %0d",
                               $time, name, exp, act));
   endtask

   // ============================================================
   // Reference model
   // ============================================================

   // Slots per frame, Business frames add VID4 and VID5
   assign frame_len = model_i ? 18 : 16;
   assign out_vec   = {pause_o, io_cycle_o, cpu_enable_o, refresh_o, tod_o, dot_o};

   always @(posedge clk_sys) begin
      rst_d      <= reset;
      cycles     <= cycles + 1;
      rfsh_gap   <= refresh_o ? 1 : rfsh_gap + 1;
      // CPU strobes since the last refresh pulse, one window is 8 frames
      cpu_cnt    <= refresh_o ? 0 : cpu_cnt + int'(cpu_enable_o);
      tgap       <= (tod_o != tod_prev) ? 1 : tgap + 1;
      tod_prev   <= tod_o;
      // Cycles since pause_i last moved
      pin_cnt    <= (pause_i != pause_prev) ? 0 : pin_cnt + 1;
      pause_prev <= pause_i;
      if (cycles >= MAX_CYCLES) begin
         report_failure("Timeout: test sequence did not finish within the cycle limit");
      end
   end

   // Outputs one cycle after a reset edge, expected {1,1,0,0,0,0}
   a_reset: assert property (@(posedge clk_sys) rst_d |-> out_vec == 6'b110000)
      else report_mismatch("{pause,io,cpu,refresh,tod,dot}", int'(6'b110000),
                           int'($sampled(out_vec)));
   a_rfsh_gap: assert property (@(posedge clk_sys) disable iff (reset)
      refresh_o && rfsh_expect != 0 |-> rfsh_gap == rfsh_expect)
      else report_mismatch("refresh_o spacing", $sampled(rfsh_expect), $sampled(rfsh_gap));
   a_rfsh_width: assert property (@(posedge clk_sys) disable iff (reset)
      refresh_o |=> !refresh_o)
      else report_mismatch("refresh_o", 0, 1);
   a_cpu_rate: assert property (@(posedge clk_sys) disable iff (reset)
      refresh_o && cpu_expect != 0 |-> cpu_cnt == cpu_expect)
      else report_mismatch("cpu_enable_o per window", $sampled(cpu_expect), $sampled(cpu_cnt));
   a_cpu_pause: assert property (@(posedge clk_sys) disable iff (reset)
      pause_o |-> !cpu_enable_o)
      else report_mismatch("cpu_enable_o", 0, 1);
   a_tod_pause: assert property (@(posedge clk_sys) disable iff (reset)
      pause_o |=> $stable(tod_o))
      else report_failure("tod_o changed while the system was paused");
   a_tod_period: assert property (@(posedge clk_sys) disable iff (reset)
      tod_expect != 0 && tod_o != tod_prev |-> tgap == tod_expect)
      else report_mismatch("tod_o period", $sampled(tod_expect), $sampled(tgap));
   // Pause takes effect within two frames, at a phase 1 wrap
   a_pause: assert property (@(posedge clk_sys) disable iff (reset)
      pause_chk && pause_i == pause_prev && pin_cnt >= 2 * frame_len - 1
      |-> pause_o == pause_i)
      else report_mismatch("pause_o", int'($sampled(pause_i)), int'($sampled(pause_o)));
   a_dots: assert property (@(posedge clk_sys) disable iff (reset)
      dot_chk |-> dot_o == dot_want)
      else report_mismatch("dot_o", int'($sampled(dot_want)), int'($sampled(dot_o)));

   // ============================================================
   // Stimulus
   // ============================================================

   task automatic wait_refresh(input int n);
      int k;
      for (k = 0; k < n; k++) begin
         do @(posedge clk_sys); while (!refresh_o);
      end
   endtask

   task automatic wait_tod_toggle(input int n);
      int   k;
      logic last;
      for (k = 0; k < n; k++) begin
         last = tod_o;
         do @(posedge clk_sys); while (tod_o == last);
      end
   endtask

   // Two frames to settle, then dot_o must hold the wanted level
   task automatic hold_dots(input logic want, input logic shuffle);
      int k;
      dot_chk  <= 1'b0;
      dot_want <= want;
      for (k = 0; k < 144; k++) begin
         @(posedge clk_sys);
         if (k == 36) begin
            dot_chk <= 1'b1;
         end
         if (shuffle) begin
            rnd = $random(seed);
            dots_i <= rnd[7:0];
         end
      end
   endtask

   initial begin
      reset      <= 1'b1;
      model_i    <= 1'b0;
      ntsc_i     <= 1'b1;
      pause_i    <= 1'b0;
      cpu_2mhz_i <= 1'b0;
      dots_i     <= 8'h00;
      de_i       <= 1'b0;
      cursor_i   <= 1'b0;
      reverse_i  <= 1'b0;
      graphics_i <= 1'b1;
      repeat (4) @(posedge clk_sys);
      reset <= 1'b0;

      // Professional refresh spacing, then 1 MHz windows
      wait_refresh(1);
      rfsh_expect <= 128;
      wait_refresh(1);
      cpu_expect <= 4;
      wait_refresh(4);
      // Switch-over window is skipped
      cpu_2mhz_i <= 1'b1;
      cpu_expect <= 0;
      wait_refresh(1);
      cpu_expect <= 8;
      wait_refresh(4);

      // Pause for three windows, then resume
      pause_chk  <= 1'b1;
      pause_i    <= 1'b1;
      cpu_expect <= 0;
      wait_refresh(3);
      pause_i <= 1'b0;
      repeat (40) @(posedge clk_sys);

      // TOD at 60 Hz then 50 Hz, first edges after a change are mixed
      wait_tod_toggle(2);
      tod_expect <= 20;
      wait_tod_toggle(5);
      tod_expect <= 0;
      ntsc_i     <= 1'b0;
      wait_tod_toggle(2);
      tod_expect <= 24;
      wait_tod_toggle(5);

      // Business model, change only at a frame start
      wait_refresh(1);
      model_i     <= 1'b1;
      rfsh_expect <= 0;
      de_i        <= 1'b1;
      dots_i      <= 8'hff;
      wait_refresh(1);
      rfsh_expect <= 144;
      hold_dots(1'b1, 1'b0);
      dots_i <= 8'h00;
      hold_dots(1'b0, 1'b0);
      cursor_i <= 1'b1;
      de_i     <= 1'b0;
      hold_dots(1'b1, 1'b0);
      cursor_i <= 1'b0;
      hold_dots(1'b0, 1'b1);

      $display("Finished with no errors");
      $finish;
   end

endmodule

// File: all.f
src/cbm2_timing_pkg.sv
src/cycle_if.sv
src/cycle_sequencer.sv
src/tod_clock.sv
src/crtc_dot_serializer.sv
src/cbm2_timing_top.sv
tb/tb_cbm2_timing.sv

// File: Makefile
TOP := tb_cbm2_timing

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -Mdir obj_dir
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --top-module cbm2_timing_top -f all.f

clean:
	rm -rf obj_dir
